//--- project.f
logic/epc_pkg.sv
logic/tag_pkg.sv
logic/cmd_decode.sv
logic/tag_fsm.sv
logic/inventory_regs.sv
logic/slot_counter.sv
logic/reply_unit.sv
logic/cmd_proc.sv
sim/tb_cmd_proc.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_cmd_proc
FILELIST = project.f
OBJDIR   = obj_dir
PASS_MSG = Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

//--- sim/tb_cmd_proc.sv
// command processor testbench
`timescale 1ns/1ps

module tb_cmd_proc;

	localparam int CLK_PERIOD   = 10;
	localparam int RESET_CYCLES = 16;
	localparam int N_CMDS       = 26;
	localparam int N_REPLIES    = 8;
	localparam int N_QUIET      = 16;
	localparam int REPLY_CYCLES = 10 + 2 * 16 + 4;   // start wait, bits with gaps, slack
	localparam int RUN_CYCLES   = RESET_CYCLES + 2 * N_CMDS + N_REPLIES * REPLY_CYCLES +
		N_QUIET * 10 + 100;

	logic                        clk_cp;
	logic                        rst_n;
	logic                        cmd_valid;
	epc_pkg::cmd_code_t          cmd;
	logic [epc_pkg::PARAM_W-1:0] param;
	logic                        crc_ok;
	logic [15:0]                 prn;
	logic                        bit_next;
	epc_pkg::link_cfg_t          link;
	logic                        en_prng_idol;
	logic                        en_prng_act;
	logic                        en_tx;
	logic                        en_crc16;
	logic                        reply_data;
	logic                        reply_complete;

	logic [31:0] lfsr = 32'h798d;
	int          errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          test_err_start;
	string       test_name;
	logic [15:0] exp_word;
	logic        exp_crc;
	logic [15:0] cap_word;
	int          cap_cnt = 0;
	int          words_checked = 0;

	cmd_proc UUT (
		.clk_cp, .rst_n, .cmd_valid, .cmd, .param, .crc_ok, .prn, .bit_next,
		.link, .en_prng_idol, .en_prng_act, .en_tx, .en_crc16, .reply_data, .reply_complete
	);

	initial begin
		clk_cp = 1'b0;
		forever #(CLK_PERIOD / 2) clk_cp = ~clk_cp;
	end

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] v;
		logic        fb;
		int          i;
		v = '0;
		for (i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[14:0], fb};
		end
		return v;
	endfunction

	function automatic logic [51:0] query_bits(input logic dr, input logic [1:0] m,
			input logic trext, input logic [1:0] sel, input logic [1:0] session,
			input logic target, input logic [3:0] q);
		return {34'b0, dr, m, trext, sel, session, target, q, 5'b0};
	endfunction

	function automatic logic [51:0] rep_bits(input logic [1:0] session);
		return {50'b0, session};
	endfunction

	function automatic logic [51:0] adjust_bits(input logic [1:0] session,
			input logic [2:0] updn);
		return {47'b0, session, updn};
	endfunction

	function automatic logic [51:0] ack_bits(input logic [15:0] rn);
		return {36'b0, rn};
	endfunction

	function automatic logic [51:0] req_rn_bits(input logic [15:0] rn);
		return {20'b0, rn, 16'b0};
	endfunction

	// reference model
	function automatic logic [3:0] predict_link(input logic [51:0] p);
		return {p[17], p[16:15], p[14]};   // dr, m, trext
	endfunction

	function automatic int predict_slot(input int q, input logic [15:0] rn);
		return int'(rn) % (1 << q);
	endfunction

	// direct replies send the number drawn with the command and slotted ones
	// the number drawn in the slot decision cycle
	function automatic logic [15:0] predict_reply(input logic direct,
			input logic [15:0] prn_cmd, input logic [15:0] prn_slot);
		return direct ? prn_cmd : prn_slot;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp,
			input logic [31:0] got);
		$display("FAILED at %0d ns: %s expected %h got %h", $time, name, exp, got);
		errors++;
	endtask

	task automatic report_problem(input string msg);
		$display("ERROR at %0d ns: %s", $time, msg);
		errors++;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_err_start = errors;
	endtask

	task automatic finish_test();
		tests_run++;
		if (errors == test_err_start) begin
			$display("test %0d %s: ok", tests_run, test_name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d error(s)", tests_run, test_name,
				errors - test_err_start);
		end
	endtask

	// one-cycle command strobe with prn moving to prn_after once it is taken
	task automatic send_cmd(input epc_pkg::cmd_code_t code, input logic [51:0] prm,
			input logic crc, input logic [15:0] prn_cmd, input logic [15:0] prn_after);
		@(posedge clk_cp);
		#1;
		cmd_valid = 1'b1;
		cmd = code;
		param = prm;
		crc_ok = crc;
		prn = prn_cmd;
		@(posedge clk_cp);
		#1;
		cmd_valid = 1'b0;
		prn = prn_after;
	endtask

	task automatic expect_quiet(input int cycles);
		logic seen;
		seen = (en_tx !== 1'b0);
		repeat (cycles) begin
			@(posedge clk_cp);
			#1;
			if (en_tx !== 1'b0)
				seen = 1'b1;
		end
		if (seen)
			report_problem("backscatter started where none was expected");
	endtask

	// bit_next every other cycle so the hold path is exercised too
	task automatic take_reply(input logic [15:0] word, input logic crc);
		int waited;
		int guard;
		int seen;
		exp_word = word;
		exp_crc = crc;
		seen = words_checked;
		waited = 0;
		while (en_tx !== 1'b1 && waited < 10) begin
			@(posedge clk_cp);
			#1;
			waited++;
		end
		if (en_tx !== 1'b1) begin
			report_problem("no backscatter started within 10 cycles");
			return;
		end
		guard = 0;
		while (en_tx === 1'b1 && guard < 40) begin
			bit_next = 1'b1;
			@(posedge clk_cp);
			#1;
			bit_next = 1'b0;
			@(posedge clk_cp);
			#1;
			guard++;
		end
		if (en_tx !== 1'b0)
			report_problem("backscatter did not end after 16 bits");
		if (reply_complete !== 1'b1)
			report_mismatch("reply_complete", 1, 32'(reply_complete));
		if (words_checked != seen + 1)
			report_problem("reply ended without a full 16-bit word");
	endtask

	// collects one bit per taken strobe and checks each full word
	always @(posedge clk_cp) begin
		if (rst_n && en_tx && bit_next) begin
			if (en_crc16 !== exp_crc)
				report_mismatch("en_crc16", 32'(exp_crc), 32'(en_crc16));
			if (en_prng_act !== 1'b1)
				report_mismatch("en_prng_act", 1, 32'(en_prng_act));
			if (en_prng_idol !== 1'b0)   // a replying tag is never in ready
				report_mismatch("en_prng_idol", 0, 32'(en_prng_idol));
			cap_word = {cap_word[14:0], reply_data};
			cap_cnt = cap_cnt + 1;
			if (cap_cnt == 16) begin
				if (cap_word !== exp_word)
					report_mismatch("reply_data word", 32'(exp_word), 32'(cap_word));
				words_checked++;
			end
		end else if (!en_tx) begin
			cap_cnt = 0;
		end
	end

	initial begin
		#(RUN_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, the run did not finish", RUN_CYCLES);
		$display("Test failed");
		$finish;
	end

	initial begin
		logic [15:0] p_cmd;
		logic [15:0] p_slot;
		logic [15:0] lk;
		logic [15:0] rn;
		logic [15:0] hdl;
		logic [51:0] qp;
		int          slot;
		int          i;
		rst_n = 1'b0;
		cmd_valid = 1'b0;
		cmd = '0;
		param = '0;
		crc_ok = 1'b0;
		prn = '0;
		bit_next = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_cp);
		#1;
		rst_n = 1'b1;

		start_test("reset values");
		@(posedge clk_cp);
		#1;
		if (en_tx !== 1'b0)
			report_mismatch("en_tx", 0, 32'(en_tx));
		if (en_prng_act !== 1'b0)
			report_mismatch("en_prng_act", 0, 32'(en_prng_act));
		if (en_crc16 !== 1'b0)
			report_mismatch("en_crc16", 0, 32'(en_crc16));
		if (reply_data !== 1'b0)
			report_mismatch("reply_data", 0, 32'(reply_data));
		if (reply_complete !== 1'b0)
			report_mismatch("reply_complete", 0, 32'(reply_complete));
		if (en_prng_idol !== 1'b1)
			report_mismatch("en_prng_idol", 1, 32'(en_prng_idol));
		if (link !== 4'b0000)
			report_mismatch("link", 0, 32'(link));
		finish_test();

		start_test("query with q zero");
		lk = rand_bits(4);
		p_cmd = rand_bits(16);
		p_slot = rand_bits(16);
		qp = query_bits(lk[3], lk[2:1], lk[0], 2'b00, 2'd0, 1'b0, 4'd0);
		send_cmd(epc_pkg::CMD_QUERY, qp, 1'b1, p_cmd, p_slot);
		if (link !== predict_link(qp))
			report_mismatch("link", 32'(predict_link(qp)), 32'(link));
		if (en_tx !== 1'b0)
			report_mismatch("en_tx", 0, 32'(en_tx));
		@(posedge clk_cp);
		#1;
		if (en_tx !== 1'b1)
			report_mismatch("en_tx", 1, 32'(en_tx));
		take_reply(predict_reply(1'b0, p_cmd, p_slot), 1'b0);
		finish_test();

		start_test("query dropped on crc or sl");
		p_cmd = rand_bits(16);
		qp = query_bits(1'b0, 2'b00, 1'b0, 2'b11, 2'd0, 1'b0, 4'd0);
		send_cmd(epc_pkg::CMD_QUERY, qp, 1'b1, p_cmd, p_cmd);
		expect_quiet(10);
		if (en_prng_idol !== 1'b1)
			report_mismatch("en_prng_idol", 1, 32'(en_prng_idol));
		p_cmd = rand_bits(16);
		qp = query_bits(1'b0, 2'b00, 1'b0, 2'b00, 2'd0, 1'b0, 4'd0);
		send_cmd(epc_pkg::CMD_QUERY, qp, 1'b0, p_cmd, p_cmd);
		expect_quiet(10);
		if (en_prng_idol !== 1'b1)
			report_mismatch("en_prng_idol", 1, 32'(en_prng_idol));
		finish_test();

		start_test("slot countdown");
		p_cmd = rand_bits(16);
		p_slot = rand_bits(16);
		if (predict_slot(3, p_cmd) == 0)
			p_cmd[0] = 1'b1;   // keep at least one slot to count
		slot = predict_slot(3, p_cmd);
		qp = query_bits(1'b0, 2'b00, 1'b0, 2'b00, 2'd0, 1'b0, 4'd3);
		send_cmd(epc_pkg::CMD_QUERY, qp, 1'b1, p_cmd, p_slot);
		expect_quiet(4);
		send_cmd(epc_pkg::CMD_QUERY_REP, rep_bits(2'd1), 1'b1, p_slot, p_slot);
		expect_quiet(4);
		for (i = 1; i <= slot; i++) begin
			p_slot = rand_bits(16);
			send_cmd(epc_pkg::CMD_QUERY_REP, rep_bits(2'd0), 1'b1, p_slot, p_slot);
			if (i < slot)
				expect_quiet(4);
		end
		take_reply(predict_reply(1'b0, p_slot, p_slot), 1'b0);
		finish_test();

		start_test("queryadjust up and down");
		// the slot wraps away from zero first so only a reload can bring a reply
		send_cmd(epc_pkg::CMD_QUERY_REP, rep_bits(2'd0), 1'b1, 16'h0000, 16'h0000);
		expect_quiet(4);
		p_slot = rand_bits(16);
		send_cmd(epc_pkg::CMD_QUERY_ADJUST, adjust_bits(2'd0, epc_pkg::UPDN_INC), 1'b1,
			16'h0000, p_slot);
		take_reply(predict_reply(1'b0, 16'h0000, p_slot), 1'b0);
		send_cmd(epc_pkg::CMD_QUERY_REP, rep_bits(2'd0), 1'b1, 16'h0000, 16'h0000);
		expect_quiet(4);
		p_slot = rand_bits(16);
		send_cmd(epc_pkg::CMD_QUERY_ADJUST, adjust_bits(2'd0, epc_pkg::UPDN_DEC), 1'b1,
			16'h0000, p_slot);
		take_reply(predict_reply(1'b0, 16'h0000, p_slot), 1'b0);
		finish_test();

		start_test("access sequence");
		send_cmd(epc_pkg::CMD_ACK, ack_bits(p_slot ^ 16'h8001), 1'b1, p_slot, p_slot);
		expect_quiet(4);
		send_cmd(epc_pkg::CMD_QUERY_REP, rep_bits(2'd0), 1'b1, p_slot, p_slot);
		expect_quiet(10);   // slot wraps so the tag stays out
		p_cmd = rand_bits(16);
		p_slot = rand_bits(16);
		qp = query_bits(1'b0, 2'b00, 1'b0, 2'b00, 2'd0, 1'b0, 4'd0);
		send_cmd(epc_pkg::CMD_QUERY, qp, 1'b1, p_cmd, p_slot);
		take_reply(predict_reply(1'b0, p_cmd, p_slot), 1'b0);
		rn = p_slot;
		send_cmd(epc_pkg::CMD_ACK, ack_bits(rn), 1'b1, rn, rn);
		expect_quiet(4);
		hdl = rand_bits(16);
		send_cmd(epc_pkg::CMD_REQ_RN, req_rn_bits(rn), 1'b1, hdl, hdl);
		if (en_tx !== 1'b1)
			report_mismatch("en_tx", 1, 32'(en_tx));
		take_reply(predict_reply(1'b1, hdl, hdl), 1'b1);
		p_cmd = rand_bits(16);
		send_cmd(epc_pkg::CMD_REQ_RN, req_rn_bits(hdl), 1'b1, p_cmd, p_cmd);
		take_reply(predict_reply(1'b1, p_cmd, p_cmd), 1'b1);
		send_cmd(epc_pkg::CMD_QUERY_REP, rep_bits(2'd0), 1'b1, p_cmd, p_cmd);
		if (en_prng_idol !== 1'b1)
			report_mismatch("en_prng_idol", 1, 32'(en_prng_idol));
		send_cmd(epc_pkg::CMD_QUERY, qp, 1'b1, p_cmd, p_cmd);
		expect_quiet(10);
		p_cmd = rand_bits(16);
		p_slot = rand_bits(16);
		qp = query_bits(1'b0, 2'b00, 1'b0, 2'b00, 2'd0, 1'b1, 4'd0);
		send_cmd(epc_pkg::CMD_QUERY, qp, 1'b1, p_cmd, p_slot);
		take_reply(predict_reply(1'b0, p_cmd, p_slot), 1'b0);
		finish_test();

		$display("tests run %0d, passed %0d, failed %0d, errors %0d", tests_run,
			tests_run - tests_failed, tests_failed, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- logic/cmd_proc.sv
// tag command processor
`timescale 1ns/1ps

module cmd_proc #(
	parameter logic [tag_pkg::RN_W-1:0] RN16_INIT   = 16'hac70,
	parameter logic [tag_pkg::RN_W-1:0] HANDLE_INIT = 16'hff31
) (
	input  logic                        clk_cp,
	input  logic                        rst_n,
	input  logic                        cmd_valid,
	input  epc_pkg::cmd_code_t          cmd,
	input  logic [epc_pkg::PARAM_W-1:0] param,
	input  logic                        crc_ok,
	input  logic [tag_pkg::RN_W-1:0]    prn,
	input  logic                        bit_next,
	output epc_pkg::link_cfg_t          link,
	output logic                        en_prng_idol,
	output logic                        en_prng_act,
	output logic                        en_tx,
	output logic                        en_crc16,
	output logic                        reply_data,
	output logic                        reply_complete
);

	tag_pkg::cmd_event_t      evt;
	tag_pkg::tag_state_t      state;
	tag_pkg::tag_action_t     act;
	tag_pkg::inv_state_t      inv;
	logic                     slot_zero;
	logic [tag_pkg::RN_W-1:0] rn16;
	logic [tag_pkg::RN_W-1:0] handle;
	logic                     state_is_sloting;

	assign state_is_sloting = state inside {tag_pkg::sloting, tag_pkg::slot_tran};

	cmd_decode u_decode (.cmd_valid, .cmd, .param, .crc_ok, .inv, .rn16, .handle, .evt);

	tag_fsm u_fsm (.clk_cp, .rst_n, .evt, .slot_zero, .state, .act, .en_prng_idol);

	inventory_regs u_inv (.clk_cp, .rst_n, .act, .param, .link, .inv);

	slot_counter u_slot (.clk_cp, .rst_n, .act, .param, .prn, .slot_zero);

	reply_unit #(
		.RN16_INIT   (RN16_INIT),
		.HANDLE_INIT (HANDLE_INIT)
	) u_reply (
		.clk_cp, .rst_n, .act, .cmd_valid, .state_is_sloting, .prn, .bit_next,
		.rn16, .handle, .en_tx, .en_prng_act, .en_crc16, .reply_data, .reply_complete
	);

endmodule

//--- logic/reply_unit.sv
// backscatter reply unit
`timescale 1ns/1ps

module reply_unit #(
	parameter logic [tag_pkg::RN_W-1:0] RN16_INIT   = '0,
	parameter logic [tag_pkg::RN_W-1:0] HANDLE_INIT = '0
) (
	input  logic                     clk_cp,
	input  logic                     rst_n,
	input  tag_pkg::tag_action_t     act,
	input  logic                     cmd_valid,
	input  logic                     state_is_sloting,
	input  logic [tag_pkg::RN_W-1:0] prn,
	input  logic                     bit_next,
	output logic [tag_pkg::RN_W-1:0] rn16,
	output logic [tag_pkg::RN_W-1:0] handle,
	output logic                     en_tx,
	output logic                     en_prng_act,
	output logic                     en_crc16,
	output logic                     reply_data,
	output logic                     reply_complete
);

	tag_pkg::tag_action_t     act_reg;
	logic                     load;
	logic [4:0]               bit_cnt;   // bits still to go out
	logic [3:0]               bit_idx;
	logic                     bs_act;
	logic [tag_pkg::RN_W-1:0] word;

	// a new command or a slot decision replaces whatever was being sent
	assign load = cmd_valid | state_is_sloting;

	always_ff @(posedge clk_cp or negedge rst_n) begin
		if (!rst_n) begin
			act_reg <= tag_pkg::do_nothing;
			bit_cnt <= '0;
		end else if (load) begin
			act_reg <= act;
			bit_cnt <= 5'd16;
		end else if (bit_next && en_tx) begin
			bit_cnt <= bit_cnt - 1'b1;
		end
	end

	always_ff @(posedge clk_cp or negedge rst_n) begin
		if (!rst_n) begin
			rn16   <= RN16_INIT;
			handle <= HANDLE_INIT;
		end else if (load) begin
			if (act inside {tag_pkg::bs_new_rn16, tag_pkg::bs_new_rn16_tran_if,
					tag_pkg::bs_new_rn16_crc16})
				rn16 <= prn;
			if (act == tag_pkg::gen_and_bs_new_handle)
				handle <= prn;
		end
	end

	assign bs_act = act_reg inside {
		tag_pkg::bs_new_rn16,
		tag_pkg::bs_new_rn16_tran_if,
		tag_pkg::gen_and_bs_new_handle,
		tag_pkg::bs_new_rn16_crc16
	};

	assign en_prng_act = bs_act;   // every reply draws a fresh number
	assign en_tx = bs_act && (bit_cnt != '0);
	assign reply_complete = bs_act && (bit_cnt == '0);
	assign en_crc16 = en_tx &&
		(act_reg inside {tag_pkg::gen_and_bs_new_handle, tag_pkg::bs_new_rn16_crc16});

	// msb first, 16 maps to bit 15
	assign word = (act_reg == tag_pkg::gen_and_bs_new_handle) ? handle : rn16;
	assign bit_idx = bit_cnt[3:0] - 4'd1;
	assign reply_data = en_tx & word[bit_idx];

endmodule

//--- logic/slot_counter.sv
// Q exponent and slot counter
`timescale 1ns/1ps

module slot_counter (
	input  logic                        clk_cp,
	input  logic                        rst_n,
	input  tag_pkg::tag_action_t        act,
	input  logic [epc_pkg::PARAM_W-1:0] param,
	input  logic [tag_pkg::RN_W-1:0]    prn,
	output logic                        slot_zero
);

	epc_pkg::query_param_t       qp;
	epc_pkg::adjust_param_t      ap;
	logic [tag_pkg::Q_W-1:0]     q;
	logic [tag_pkg::Q_W-1:0]     q_adj;
	logic                        adj_step;
	logic [tag_pkg::SLOT_W-1:0]  slot;

	// keep the low q bits of the random number
	function automatic logic [tag_pkg::SLOT_W-1:0] draw_slot(
		input logic [tag_pkg::Q_W-1:0]  qv,
		input logic [tag_pkg::RN_W-1:0] rn
	);
		return rn[tag_pkg::SLOT_W-1:0] & ~({tag_pkg::SLOT_W{1'b1}} << qv);
	endfunction

	assign qp = epc_pkg::query_param_t'(param);
	assign ap = epc_pkg::adjust_param_t'(param);

	always_comb begin
		adj_step = 1'b1;
		case (ap.updn)
			epc_pkg::UPDN_INC: q_adj = q + 1'b1;   // wraps in 4 bits
			epc_pkg::UPDN_DEC: q_adj = q - 1'b1;
			default: begin
				q_adj = q;
				adj_step = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk_cp or negedge rst_n) begin
		if (!rst_n) begin
			q    <= '0;
			slot <= '0;
		end else begin
			case (act)
				tag_pkg::init_inventory: begin
					q    <= qp.q;
					slot <= draw_slot(qp.q, prn);
				end
				tag_pkg::adj_q, tag_pkg::adj_q_tran_if: begin
					if (adj_step) begin
						q    <= q_adj;
						slot <= draw_slot(q_adj, prn);
					end
				end
				tag_pkg::dec_slot, tag_pkg::dec_slot_tran_if: slot <= slot - 1'b1;
				default: ;
			endcase
		end
	end

	assign slot_zero = (slot == '0);

endmodule

//--- logic/inventory_regs.sv
// inventory and link registers
`timescale 1ns/1ps

module inventory_regs (
	input  logic                        clk_cp,
	input  logic                        rst_n,
	input  tag_pkg::tag_action_t        act,
	input  logic [epc_pkg::PARAM_W-1:0] param,
	output epc_pkg::link_cfg_t          link,
	output tag_pkg::inv_state_t         inv
);

	epc_pkg::query_param_t qp;
	logic                  flip_flag;

	assign qp = epc_pkg::query_param_t'(param);

	// tag leaves the round after being acknowledged
	assign flip_flag = act inside {
		tag_pkg::tran_if,
		tag_pkg::bs_new_rn16_tran_if,
		tag_pkg::dec_slot_tran_if,
		tag_pkg::adj_q_tran_if
	};

	always_ff @(posedge clk_cp or negedge rst_n) begin
		if (!rst_n) begin
			link <= '0;
		end else if (act == tag_pkg::init_inventory) begin
			link.dr    <= qp.dr;
			link.m     <= qp.m;
			link.trext <= qp.trext;
		end
	end

	always_ff @(posedge clk_cp or negedge rst_n) begin
		if (!rst_n) begin
			inv.session  <= 2'b00;
			inv.sl       <= 2'b10;   // deasserted, only Select would change it
			inv.inv_flag <= 4'b0000;   // all sessions on A
		end else begin
			if (act == tag_pkg::init_inventory)
				inv.session <= qp.session;
			if (flip_flag)
				inv.inv_flag[inv.session] <= ~inv.inv_flag[inv.session];
		end
	end

endmodule

//--- logic/tag_fsm.sv
// tag state machine
`timescale 1ns/1ps

module tag_fsm (
	input  logic                 clk_cp,
	input  logic                 rst_n,
	input  tag_pkg::cmd_event_t  evt,
	input  logic                 slot_zero,
	output tag_pkg::tag_state_t  state,
	output tag_pkg::tag_action_t act,
	output logic                 en_prng_idol
);

	tag_pkg::tag_state_t next_state;

	always_ff @(posedge clk_cp or negedge rst_n) begin
		if (!rst_n)
			state <= tag_pkg::ready;
		else
			state <= next_state;
	end

	assign en_prng_idol = (state == tag_pkg::ready);   // free-running prng while idle

	always_comb begin
		next_state = state;
		act = tag_pkg::do_nothing;
		case (state)
			tag_pkg::ready: begin
				if (evt.kind == tag_pkg::query) begin
					next_state = evt.query_match ? tag_pkg::sloting : tag_pkg::ready;
					act = evt.query_match ? tag_pkg::init_inventory : tag_pkg::do_nothing;
				end
			end

			// one cycle here so the freshly loaded slot can be looked at
			tag_pkg::sloting, tag_pkg::slot_tran: begin
				if (slot_zero) begin
					next_state = tag_pkg::reply;
					act = (state == tag_pkg::slot_tran) ?
						tag_pkg::bs_new_rn16_tran_if : tag_pkg::bs_new_rn16;
				end else begin
					next_state = tag_pkg::arbitrate;
					act = (state == tag_pkg::slot_tran) ? tag_pkg::tran_if : tag_pkg::do_nothing;
				end
			end

			tag_pkg::arbitrate, tag_pkg::reply: begin
				case (evt.kind)
					tag_pkg::query: begin
						next_state = evt.query_match ? tag_pkg::sloting : tag_pkg::ready;
						act = evt.query_match ? tag_pkg::init_inventory : tag_pkg::do_nothing;
					end
					tag_pkg::query_rep: begin
						if (evt.session_match) begin
							next_state = (state == tag_pkg::reply) ?
								tag_pkg::arbitrate : tag_pkg::sloting;
							act = tag_pkg::dec_slot;
						end
					end
					tag_pkg::query_adjust: begin
						if (evt.session_match) begin
							next_state = tag_pkg::sloting;
							act = tag_pkg::adj_q;
						end
					end
					tag_pkg::ack: begin
						if (state == tag_pkg::reply) begin
							next_state = evt.ack_rn16_match ? tag_pkg::acknowledged : tag_pkg::arbitrate;
							act = evt.ack_rn16_match ? tag_pkg::ack_ok : tag_pkg::do_nothing;
						end
					end
					tag_pkg::nak, tag_pkg::req_rn: next_state = tag_pkg::arbitrate;
					default: ;
				endcase
			end

			tag_pkg::acknowledged, tag_pkg::secured: begin
				case (evt.kind)
					tag_pkg::query: begin
						next_state = evt.query_match ? tag_pkg::slot_tran : tag_pkg::ready;
						act = evt.query_match ? tag_pkg::init_inventory : tag_pkg::do_nothing;
					end
					tag_pkg::query_rep: begin
						if (evt.session_match) begin
							next_state = tag_pkg::ready;   // leaves the round
							act = tag_pkg::dec_slot_tran_if;
						end
					end
					tag_pkg::query_adjust: begin
						if (evt.session_match) begin
							next_state = tag_pkg::ready;
							act = tag_pkg::adj_q_tran_if;
						end
					end
					tag_pkg::ack: begin
						if (state == tag_pkg::acknowledged && evt.ack_rn16_match)
							act = tag_pkg::ack_ok;
						else if (!(state == tag_pkg::secured && evt.ack_handle_match))
							next_state = tag_pkg::arbitrate;
					end
					tag_pkg::nak: next_state = tag_pkg::arbitrate;
					tag_pkg::req_rn: begin
						if (state == tag_pkg::acknowledged && evt.req_rn16_match) begin
							next_state = tag_pkg::secured;
							act = tag_pkg::gen_and_bs_new_handle;
						end else if (state == tag_pkg::secured && evt.req_handle_match) begin
							act = tag_pkg::bs_new_rn16_crc16;
						end
					end
					default: ;
				endcase
			end

			default: next_state = tag_pkg::arbitrate;
		endcase
	end

endmodule

//--- logic/cmd_decode.sv
// command decoder
`timescale 1ns/1ps

module cmd_decode (
	input  logic                        cmd_valid,
	input  epc_pkg::cmd_code_t          cmd,
	input  logic [epc_pkg::PARAM_W-1:0] param,
	input  logic                        crc_ok,
	input  tag_pkg::inv_state_t         inv,
	input  logic [tag_pkg::RN_W-1:0]    rn16,
	input  logic [tag_pkg::RN_W-1:0]    handle,
	output tag_pkg::cmd_event_t         evt
);

	epc_pkg::query_param_t  qp;
	epc_pkg::adjust_param_t ap;
	epc_pkg::rep_param_t    rp;
	epc_pkg::ack_param_t    kp;
	epc_pkg::req_rn_param_t rq;

	assign qp = epc_pkg::query_param_t'(param);
	assign ap = epc_pkg::adjust_param_t'(param);
	assign rp = epc_pkg::rep_param_t'(param);
	assign kp = epc_pkg::ack_param_t'(param);
	assign rq = epc_pkg::req_rn_param_t'(param);

	always_comb begin
		evt.kind = tag_pkg::none;
		if (cmd_valid) begin
			case (cmd)
				epc_pkg::CMD_QUERY:        if (crc_ok) evt.kind = tag_pkg::query;
				epc_pkg::CMD_REQ_RN:       if (crc_ok) evt.kind = tag_pkg::req_rn;
				epc_pkg::CMD_QUERY_REP:    evt.kind = tag_pkg::query_rep;
				epc_pkg::CMD_QUERY_ADJUST: evt.kind = tag_pkg::query_adjust;
				epc_pkg::CMD_ACK:          evt.kind = tag_pkg::ack;
				epc_pkg::CMD_NAK:          evt.kind = tag_pkg::nak;
				default:                   evt.kind = tag_pkg::none;
			endcase
		end

		// sel 0x means all tags, 1x selects on the SL flag
		evt.query_match = (inv.inv_flag[qp.session] == qp.target) &&
			(!qp.sel[1] || qp.sel == inv.sl);
		evt.session_match = (cmd == epc_pkg::CMD_QUERY_ADJUST) ?
			(ap.session == inv.session) : (rp.session == inv.session);
		evt.ack_rn16_match   = kp.rn == rn16;
		evt.ack_handle_match = kp.rn == handle;
		evt.req_rn16_match   = rq.rn == rn16;
		evt.req_handle_match = rq.rn == handle;
	end

endmodule

//--- logic/tag_pkg.sv
// tag internal definitions
package tag_pkg;

	localparam int RN_W   = 16;
	localparam int SLOT_W = 15;
	localparam int Q_W    = 4;

	typedef enum logic [3:0] {
		ready        = 4'h0,
		sloting      = 4'h1,
		arbitrate    = 4'h2,
		reply        = 4'h3,
		acknowledged = 4'h4,
		slot_tran    = 4'h5,
		secured      = 4'h7
	} tag_state_t;

	typedef enum logic [3:0] {
		do_nothing            = 4'h0,
		init_inventory        = 4'h1,
		adj_q                 = 4'h2,
		dec_slot              = 4'h3,
		bs_new_rn16           = 4'h4,
		bs_new_rn16_tran_if   = 4'h5,
		tran_if               = 4'h6,
		dec_slot_tran_if      = 4'h7,
		adj_q_tran_if         = 4'h8,
		ack_ok                = 4'h9,
		gen_and_bs_new_handle = 4'ha,
		bs_new_rn16_crc16     = 4'hb
	} tag_action_t;

	typedef struct packed {
		logic [1:0] session;
		logic [1:0] sl;
		logic [3:0] inv_flag;   // one per session
	} inv_state_t;

	typedef enum logic [2:0] {
		none,
		query,
		query_rep,
		query_adjust,
		ack,
		nak,
		req_rn
	} cmd_kind_t;

	typedef struct packed {
		cmd_kind_t kind;
		logic      query_match;
		logic      session_match;
		logic      ack_rn16_match;
		logic      req_rn16_match;
		logic      req_handle_match;
		logic      ack_handle_match;
	} cmd_event_t;

endpackage

//--- logic/epc_pkg.sv
// EPC Gen2 air protocol definitions
package epc_pkg;

	typedef logic [7:0] cmd_code_t;

	localparam cmd_code_t CMD_QUERY_REP    = 8'b0000_1100;
	localparam cmd_code_t CMD_ACK          = 8'b0000_1101;
	localparam cmd_code_t CMD_QUERY        = 8'b0011_1000;
	localparam cmd_code_t CMD_QUERY_ADJUST = 8'b0011_1001;
	localparam cmd_code_t CMD_NAK          = 8'b1100_0000;
	localparam cmd_code_t CMD_REQ_RN       = 8'b1100_0001;

	localparam int PARAM_W = 52;

	// query payload sits right-aligned, crc-5 at the bottom
	typedef struct packed {
		logic [PARAM_W-19:0] rsvd;
		logic                dr;      // divide ratio
		logic [1:0]          m;       // cycles per symbol
		logic                trext;   // pilot tone
		logic [1:0]          sel;
		logic [1:0]          session;
		logic                target;
		logic [3:0]          q;
		logic [4:0]          crc5;
	} query_param_t;

	typedef struct packed {
		logic [PARAM_W-6:0] rsvd;
		logic [1:0]         session;
		logic [2:0]         updn;
	} adjust_param_t;

	typedef struct packed {
		logic [PARAM_W-3:0] rsvd;
		logic [1:0]         session;
	} rep_param_t;

	typedef struct packed {
		logic [PARAM_W-17:0] rsvd;
		logic [15:0]         rn;
	} ack_param_t;

	typedef struct packed {
		logic [PARAM_W-33:0] rsvd;
		logic [15:0]         rn;      // rn16 or handle
		logic [15:0]         crc16;
	} req_rn_param_t;

	localparam logic [2:0] UPDN_INC = 3'b110;
	localparam logic [2:0] UPDN_DEC = 3'b011;

	typedef struct packed {
		logic       dr;
		logic [1:0] m;
		logic       trext;
	} link_cfg_t;

endpackage
